/* compile.f */
rtl/ahb_pkg.sv
rtl/soc_map_pkg.sv
rtl/ahb_ctrl.sv
rtl/clint.sv
rtl/uart_tx.sv
rtl/periph_top.sv
dv/tb_periph_top.sv

/* Bender.yml */
package:
  name: periph_top

sources:
  - rtl/ahb_pkg.sv
  - rtl/soc_map_pkg.sv
  - rtl/ahb_ctrl.sv
  - rtl/clint.sv
  - rtl/uart_tx.sv
  - rtl/periph_top.sv
  - target: test
    files:
      - dv/tb_periph_top.sv

/* dv/tb_periph_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_periph_top;
    import ahb_pkg::*;
    import soc_map_pkg::*;

    localparam int TEST_DIV      = 12;
    localparam int N_TICKS       = 8;
    localparam int TOGGLE_CYCLES = 4;
    // reset, three frames, the rtc toggles, then room for the bus transfers
    localparam int CYCLE_LIMIT   = 16 + 3 * TEST_DIV * 10 + (N_TICKS + 1) * TOGGLE_CYCLES
                                   + 1000;

    localparam logic [31:0] CLINT_BASE = 32'h0200_0000;
    localparam logic [31:0] PLIC_BASE  = 32'h0C00_1000;
    localparam logic [31:0] UART_BASE  = 32'h1000_2000;
    localparam logic [31:0] SPI_BASE   = 32'h1000_3000;
    localparam logic [31:0] NOMAP_BASE = 32'h1000_7000;

    logic        clk;
    logic        reset;
    logic        rtc_toggle;
    ahb_req_t    ahb_req;
    ahb_rsp_t    ahb_rsp;
    logic        tx;
    irq_t        irq;

    logic [15:0] lfsr_q;
    int          n_value_err;
    int          n_other_err;
    int          cycle_count;
    logic [31:0] cmp_lo;   // last mtimecmp low half written

    periph_top #(
        .CLKS_PER_BIT (16),
        .SYNC_STAGES  (2)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .rtc_toggle (rtc_toggle),
        .ahb_req    (ahb_req),
        .ahb_rsp    (ahb_rsp),
        .tx         (tx),
        .irq        (irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("errors: %0d wrong value, %0d other", n_value_err, n_other_err);
        $display("=== FAIL ===");
        $finish;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {1'b0, state[15:1]} ^ (state[0] ? 16'hB400 : 16'h0000);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERR t=%0t %s: got %h, expected %h", $time, name, got, exp);
        n_value_err++;
    endtask

    task automatic report_failure(input string what);
        $display("t=%0t %s", $time, what);
        n_other_err++;
    endtask

    // one non-pipelined transfer that returns after the data phase
    task automatic bus_xfer(
        input  logic        write,
        input  logic [31:0] addr,
        input  logic [31:0] wdata,
        output logic [31:0] rdata,
        output logic        resp,
        output logic        first_resp,
        output int          waits
    );
        ahb_req.hsel   = 1'b1;
        ahb_req.haddr  = addr;
        ahb_req.htrans = HTRANS_NONSEQ;
        ahb_req.hwrite = write;
        ahb_req.hsize  = 3'b010;
        while (ahb_rsp.hready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        ahb_req.hsel   = 1'b0;
        ahb_req.htrans = HTRANS_IDLE;
        ahb_req.hwdata = wdata;   // held through wait states
        first_resp     = ahb_rsp.hresp;
        waits          = 0;
        while (ahb_rsp.hready !== 1'b1) begin
            waits++;
            @(posedge clk);
            #1;
        end
        rdata = ahb_rsp.hrdata;
        resp  = ahb_rsp.hresp;
        @(posedge clk);
        #1;
    endtask

    task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        resp;
        logic        first_resp;
        int          waits;
        bus_xfer(1'b1, addr, data, rdata, resp, first_resp, waits);
        if (resp !== HRESP_OKAY) begin
            report_failure($sformatf("write to %h got an ERROR response", addr));
        end
    endtask

    task automatic ahb_read(input logic [31:0] addr, input logic [31:0] exp, input string name);
        logic [31:0] rdata;
        logic        resp;
        logic        first_resp;
        int          waits;
        bus_xfer(1'b0, addr, 32'd0, rdata, resp, first_resp, waits);
        if (resp !== HRESP_OKAY) begin
            report_failure($sformatf("read of %s got an ERROR response", name));
        end
        if (rdata !== exp) report_mismatch(name, rdata, exp);
    endtask

    task automatic toggle_rtc();
        rtc_toggle = ~rtc_toggle;
        repeat (TOGGLE_CYCLES) @(posedge clk);
        #1;
    endtask

    task automatic wait_uart_done();
        while (irq.uart !== 1'b1) begin
            @(posedge clk);
            #1;
        end
    endtask

    // mid-bit sampling from the falling edge of the start bit
    task automatic receive_frame(input logic [7:0] exp, input logic expect_stall);
        logic [7:0] got;
        @(negedge tx);
        repeat (TEST_DIV / 2) @(posedge clk);
        #1;
        if (tx !== 1'b0) report_mismatch("tx start bit", tx, 0);
        for (int i = 0; i < 8; i++) begin
            repeat (TEST_DIV) @(posedge clk);
            #1;
            got[i] = tx;
            if (expect_stall && ahb_rsp.hready !== 1'b0) begin
                report_mismatch("hready", ahb_rsp.hready, 0);
            end
        end
        repeat (TEST_DIV) @(posedge clk);
        #1;
        if (tx !== 1'b1) report_mismatch("tx stop bit", tx, 1);
        if (expect_stall && ahb_rsp.hready !== 1'b0) begin
            report_mismatch("hready", ahb_rsp.hready, 0);
        end
        if (got !== exp) report_mismatch("tx byte", got, exp);
    endtask

    task automatic error_access(input logic [31:0] addr, input logic write);
        logic [31:0] rdata;
        logic        resp;
        logic        first_resp;
        int          waits;
        bus_xfer(write, addr, 32'hFFFF_FFFF, rdata, resp, first_resp, waits);
        if (first_resp !== HRESP_ERROR) report_mismatch("hresp first", first_resp, HRESP_ERROR);
        if (waits != 1) report_failure($sformatf("access to %h took %0d wait cycles, not 1",
                                                 addr, waits));
        if (resp !== HRESP_ERROR) report_mismatch("hresp last", resp, HRESP_ERROR);
    endtask

    task automatic check_reset_state();
        if (tx !== 1'b1) report_mismatch("tx", tx, 1);
        if (irq !== 3'b000) report_mismatch("irq", irq, 0);
        if (ahb_rsp.hready !== 1'b1) report_mismatch("hready", ahb_rsp.hready, 1);
        ahb_read(CLINT_BASE + CLINT_MTIME_LO, 32'd0, "mtime_lo");
        ahb_read(CLINT_BASE + CLINT_MTIME_HI, 32'd0, "mtime_hi");
        ahb_read(CLINT_BASE + CLINT_MTIMECMP_LO, 32'hFFFF_FFFF, "mtimecmp_lo");
        ahb_read(CLINT_BASE + CLINT_MTIMECMP_HI, 32'hFFFF_FFFF, "mtimecmp_hi");
        ahb_read(UART_BASE + UART_STATUS, 32'd0, "status");
        ahb_read(UART_BASE + UART_DIV, 32'd16, "div");
    endtask

    task automatic clint_register_access();
        logic [31:0] lo;
        logic [31:0] hi;
        lo = take_bits(32);
        hi = take_bits(32);
        ahb_write(CLINT_BASE + CLINT_MTIMECMP_LO, lo);
        ahb_write(CLINT_BASE + CLINT_MTIMECMP_HI, hi);
        ahb_read(CLINT_BASE + CLINT_MTIMECMP_LO, lo, "mtimecmp_lo");
        ahb_read(CLINT_BASE + CLINT_MTIMECMP_HI, hi, "mtimecmp_hi");
        ahb_write(CLINT_BASE + CLINT_MSIP, 32'd1);
        if (irq.software !== 1'b1) report_mismatch("irq.software", irq.software, 1);
        ahb_read(CLINT_BASE + CLINT_MSIP, 32'd1, "msip");
        ahb_write(CLINT_BASE + CLINT_MSIP, 32'd0);
        if (irq.software !== 1'b0) report_mismatch("irq.software", irq.software, 0);
    endtask

    task automatic timer_interrupt();
        cmp_lo = N_TICKS;
        ahb_write(CLINT_BASE + CLINT_MTIMECMP_LO, cmp_lo);
        ahb_write(CLINT_BASE + CLINT_MTIMECMP_HI, 32'd0);
        repeat (N_TICKS - 1) toggle_rtc();
        repeat (8) @(posedge clk);   // let the synchronizer settle
        #1;
        ahb_read(CLINT_BASE + CLINT_MTIME_LO, N_TICKS - 1, "mtime_lo");
        if (irq.timer !== 1'b0) report_mismatch("irq.timer", irq.timer, 0);
        toggle_rtc();
        repeat (8) @(posedge clk);
        #1;
        ahb_read(CLINT_BASE + CLINT_MTIME_LO, N_TICKS, "mtime_lo");
        ahb_read(CLINT_BASE + CLINT_MTIME_HI, 32'd0, "mtime_hi");
        if (irq.timer !== 1'b1) report_mismatch("irq.timer", irq.timer, 1);
        cmp_lo = N_TICKS + 100;
        ahb_write(CLINT_BASE + CLINT_MTIMECMP_LO, cmp_lo);
        @(posedge clk);   // registered compare
        #1;
        if (irq.timer !== 1'b0) report_mismatch("irq.timer", irq.timer, 0);
    endtask

    task automatic uart_frame();
        logic [7:0] data;
        data = 8'(take_bits(8));
        ahb_write(UART_BASE + UART_DIV, TEST_DIV);
        ahb_read(UART_BASE + UART_DIV, TEST_DIV, "div");
        fork
            receive_frame(data, 1'b0);
            ahb_write(UART_BASE + UART_TXDATA, {24'd0, data});
        join
        wait_uart_done();
        ahb_read(UART_BASE + UART_STATUS, 32'h2, "status");
        ahb_write(UART_BASE + UART_STATUS, 32'h2);
        if (irq.uart !== 1'b0) report_mismatch("irq.uart", irq.uart, 0);
        ahb_read(UART_BASE + UART_STATUS, 32'h0, "status");
    endtask

    task automatic uart_back_pressure();
        logic [7:0] first;
        logic [7:0] second;
        first  = 8'(take_bits(8));
        second = 8'(take_bits(8));
        fork
            begin
                receive_frame(first, 1'b1);
                receive_frame(second, 1'b0);
            end
            begin
                ahb_write(UART_BASE + UART_TXDATA, {24'd0, first});
                ahb_read(UART_BASE + UART_STATUS, 32'h1, "status");
                ahb_write(UART_BASE + UART_TXDATA, {24'd0, second});   // stalls
                ahb_write(UART_BASE + UART_STATUS, 32'h2);   // first frame's done
            end
        join
        wait_uart_done();
        ahb_write(UART_BASE + UART_STATUS, 32'h2);
    endtask

    task automatic error_response();
        logic [31:0] bases [3];
        bases[0] = PLIC_BASE;
        bases[1] = SPI_BASE;
        bases[2] = NOMAP_BASE;
        for (int i = 0; i < 3; i++) begin
            error_access(bases[i] + 32'h08, 1'b1);   // mtimecmp_lo and div offset
            error_access(bases[i] + 32'h00, 1'b1);
            error_access(bases[i] + 32'h08, 1'b0);
        end
        ahb_read(CLINT_BASE + CLINT_MTIMECMP_LO, cmp_lo, "mtimecmp_lo");
        ahb_read(CLINT_BASE + CLINT_MSIP, 32'd0, "msip");
        ahb_read(UART_BASE + UART_DIV, TEST_DIV, "div");
        ahb_read(UART_BASE + UART_STATUS, 32'h0, "status");
    endtask

    initial begin
        reset       = 1'b1;
        rtc_toggle  = 1'b0;
        ahb_req     = '0;
        lfsr_q      = 16'd28;
        cmp_lo      = '1;
        n_value_err = 0;
        n_other_err = 0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        check_reset_state();
        clint_register_access();
        timer_interrupt();
        uart_frame();
        uart_back_pressure();
        error_response();
        $display("errors: %0d wrong value, %0d other", n_value_err, n_other_err);
        if (n_value_err + n_other_err == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/periph_top.sv */
`timescale 1ns/1ps
`default_nettype none

module periph_top #(
    parameter int CLKS_PER_BIT = 16,
    parameter int SYNC_STAGES  = 2
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      rtc_toggle,   // async
    input  wire ahb_pkg::ahb_req_t   ahb_req,
    output wire ahb_pkg::ahb_rsp_t   ahb_rsp,
    output wire                      tx,
    output wire soc_map_pkg::irq_t   irq
);
    import soc_map_pkg::*;

    wire periph_req_t  clint_req;
    wire periph_req_t  uart_req;
    wire [31:0]        clint_rdata;
    wire uart_rsp_t    uart_rsp;

    ahb_ctrl u_ahb_ctrl (
        .clk         (clk         ),
        .reset       (reset       ),
        .ahb_req     (ahb_req     ),
        .ahb_rsp     (ahb_rsp     ),
        .clint_req   (clint_req   ),
        .uart_req    (uart_req    ),
        .clint_rdata (clint_rdata ),
        .uart_rsp    (uart_rsp    )
    );

    clint #(
        .SYNC_STAGES (SYNC_STAGES )
    ) u_clint (
        .clk          (clk          ),
        .reset        (reset        ),
        .rtc_toggle   (rtc_toggle   ),
        .req          (clint_req    ),
        .rdata        (clint_rdata  ),
        .irq_timer    (irq.timer    ),
        .irq_software (irq.software )
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT )
    ) u_uart_tx (
        .clk      (clk      ),
        .reset    (reset    ),
        .req      (uart_req ),
        .rsp      (uart_rsp ),
        .tx       (tx       ),
        .irq_uart (irq.uart )
    );

endmodule

`default_nettype wire

/* rtl/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  wire                            clk,
    input  wire                            reset,
    input  wire soc_map_pkg::periph_req_t  req,
    output soc_map_pkg::uart_rsp_t         rsp,
    output logic                           tx,
    output logic                           irq_uart
);
    import soc_map_pkg::*;

    logic [15:0] div_q;       // cycles per bit
    logic [15:0] clk_cnt_q;
    logic [3:0]  bit_cnt_q;
    logic [9:0]  shift_q;     // stop, data, start
    logic        busy_q;
    logic        done_q;

    logic        wr_txdata;
    logic        wr_status;
    logic        wr_div;
    logic        frame_start;
    logic        bit_end;
    logic        frame_end;

    assign wr_txdata = req.wr && (req.offset == UART_TXDATA);
    assign wr_status = req.wr && (req.offset == UART_STATUS);
    assign wr_div    = req.wr && (req.offset == UART_DIV);

    assign frame_start = wr_txdata && !busy_q;
    // div of 0 or 1 gives one cycle per bit
    assign bit_end     = busy_q && ((17'(clk_cnt_q) + 17'd1) >= 17'(div_q));
    assign frame_end   = bit_end && (bit_cnt_q == 4'd9);

    always_ff @(posedge clk) begin
        if (reset) begin
            div_q <= 16'(CLKS_PER_BIT);
        end else if (wr_div) begin
            div_q <= req.wdata[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q    <= 1'b0;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            shift_q   <= '1;   // line idles high
        end else if (frame_start) begin
            busy_q    <= 1'b1;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            shift_q   <= {1'b1, req.wdata[7:0], 1'b0};
        end else if (bit_end) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= bit_cnt_q + 4'd1;
            shift_q   <= {1'b1, shift_q[9:1]};   // lsb first, refill with idle
            if (frame_end) begin
                busy_q <= 1'b0;
            end
        end else if (busy_q) begin
            clk_cnt_q <= clk_cnt_q + 16'd1;
        end
    end

    assign tx = shift_q[0];

    // sticky done, cleared by writing status bit1
    always_ff @(posedge clk) begin
        if (reset) begin
            done_q <= 1'b0;
        end else if (frame_end) begin
            done_q <= 1'b1;
        end else if (wr_status && req.wdata[1]) begin
            done_q <= 1'b0;
        end
    end

    assign irq_uart = done_q;

    always_comb begin
        rsp.stall = wr_txdata && busy_q;
        rsp.rdata = '0;
        if (req.rd) begin
            case (req.offset)
                UART_STATUS: rsp.rdata = {30'd0, done_q, busy_q};
                UART_DIV:    rsp.rdata = {16'd0, div_q};
                default:     rsp.rdata = '0;   // txdata is write only
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/clint.sv */
`timescale 1ns/1ps
`default_nettype none

module clint #(
    parameter int SYNC_STAGES = 2
) (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            rtc_toggle,   // async
    input  wire soc_map_pkg::periph_req_t  req,
    output logic [31:0]                    rdata,
    output logic                           irq_timer,
    output logic                           irq_software
);
    import soc_map_pkg::*;

    logic [SYNC_STAGES-1:0] rtc_sync_q;
    logic                   rtc_last_q;
    logic                   rtc_tick;

    logic [63:0]            mtime_q;
    logic [63:0]            mtimecmp_q;
    logic                   msip_q;

    logic                   wr_msip;
    logic                   wr_cmp_lo;
    logic                   wr_cmp_hi;
    logic                   wr_time_lo;
    logic                   wr_time_hi;

    // synchronizer chain, then edge detect on its output
    always_ff @(posedge clk) begin
        if (reset) begin
            rtc_sync_q <= '0;
            rtc_last_q <= 1'b0;
        end else begin
            rtc_sync_q <= SYNC_STAGES'({rtc_sync_q, rtc_toggle});
            rtc_last_q <= rtc_sync_q[SYNC_STAGES-1];
        end
    end

    assign rtc_tick = rtc_sync_q[SYNC_STAGES-1] ^ rtc_last_q; // both edges count

    assign wr_msip    = req.wr && (req.offset == CLINT_MSIP);
    assign wr_cmp_lo  = req.wr && (req.offset == CLINT_MTIMECMP_LO);
    assign wr_cmp_hi  = req.wr && (req.offset == CLINT_MTIMECMP_HI);
    assign wr_time_lo = req.wr && (req.offset == CLINT_MTIME_LO);
    assign wr_time_hi = req.wr && (req.offset == CLINT_MTIME_HI);

    // a bus write wins over a tick in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            mtime_q <= '0;
        end else if (wr_time_lo) begin
            mtime_q[31:0] <= req.wdata;
        end else if (wr_time_hi) begin
            mtime_q[63:32] <= req.wdata;
        end else if (rtc_tick) begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mtimecmp_q <= '1;   // no timer irq out of reset
        end else if (wr_cmp_lo) begin
            mtimecmp_q[31:0] <= req.wdata;
        end else if (wr_cmp_hi) begin
            mtimecmp_q[63:32] <= req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            msip_q <= 1'b0;
        end else if (wr_msip) begin
            msip_q <= req.wdata[0];
        end
    end

    // compare is registered, irq follows a register change by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            irq_timer <= 1'b0;
        end else begin
            irq_timer <= (mtime_q >= mtimecmp_q);
        end
    end

    assign irq_software = msip_q;

    always_comb begin
        rdata = '0;
        if (req.rd) begin
            case (req.offset)
                CLINT_MSIP:        rdata = {31'd0, msip_q};
                CLINT_MTIMECMP_LO: rdata = mtimecmp_q[31:0];
                CLINT_MTIMECMP_HI: rdata = mtimecmp_q[63:32];
                CLINT_MTIME_LO:    rdata = mtime_q[31:0];
                CLINT_MTIME_HI:    rdata = mtime_q[63:32];
                default:           rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/ahb_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ahb_ctrl (
    input  wire                          clk,
    input  wire                          reset,
    input  wire ahb_pkg::ahb_req_t       ahb_req,
    output ahb_pkg::ahb_rsp_t            ahb_rsp,
    output soc_map_pkg::periph_req_t     clint_req,
    output soc_map_pkg::periph_req_t     uart_req,
    input  wire [31:0]                   clint_rdata,
    input  wire soc_map_pkg::uart_rsp_t  uart_rsp
);
    import ahb_pkg::*;
    import soc_map_pkg::*;

    typedef enum logic {
        ERR_IDLE,
        ERR_LAST    // second cycle, hready goes back high
    } err_state_e;

    logic       addr_valid_q;
    logic       write_q;
    region_e    region_q;
    logic [7:0] offset_q;
    err_state_e err_state_q;

    logic       trans_start;
    logic       hit_clint;
    logic       hit_uart;
    logic       err_first;

    assign trans_start = ahb_req.hsel &&
                         (ahb_req.htrans == HTRANS_NONSEQ || ahb_req.htrans == HTRANS_SEQ);

    // address phase is only taken when the previous data phase ends
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_valid_q <= 1'b0;
            write_q      <= 1'b0;
            region_q     <= REGION_CLINT;
            offset_q     <= '0;
        end else if (ahb_rsp.hready) begin
            addr_valid_q <= trans_start;
            write_q      <= ahb_req.hwrite;
            region_q     <= region_e'(ahb_req.haddr[15:12]);
            offset_q     <= ahb_req.haddr[7:0];
        end
    end

    always_comb begin
        hit_clint = 1'b0;
        hit_uart  = 1'b0;
        err_first = 1'b0;
        if (addr_valid_q) begin
            case (region_q)
                REGION_CLINT: hit_clint = 1'b1;
                REGION_UART:  hit_uart  = 1'b1;
                default:      err_first = (err_state_q == ERR_IDLE); // plic, spi, unmapped
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            err_state_q <= ERR_IDLE;
        end else if (err_first) begin
            err_state_q <= ERR_LAST;
        end else begin
            err_state_q <= ERR_IDLE;
        end
    end

    // peripheral strobes, uart wr stays up while it stalls
    always_comb begin
        clint_req.wr     = hit_clint && write_q;
        clint_req.rd     = hit_clint && !write_q;
        clint_req.offset = offset_q;
        clint_req.wdata  = ahb_req.hwdata;

        uart_req.wr      = hit_uart && write_q;
        uart_req.rd      = hit_uart && !write_q;
        uart_req.offset  = offset_q;
        uart_req.wdata   = ahb_req.hwdata;
    end

    always_comb begin
        ahb_rsp.hready = !err_first && !uart_rsp.stall;
        ahb_rsp.hresp  = (err_first || err_state_q == ERR_LAST) ? HRESP_ERROR : HRESP_OKAY;
        case (region_q)
            REGION_CLINT: ahb_rsp.hrdata = clint_rdata;
            REGION_UART:  ahb_rsp.hrdata = uart_rsp.rdata;
            default:      ahb_rsp.hrdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/soc_map_pkg.sv */
`default_nettype none

package soc_map_pkg;

    // region select from haddr[15:12]
    typedef enum logic [3:0] {
        REGION_CLINT = 4'd0,
        REGION_PLIC  = 4'd1,   // no hardware behind it
        REGION_UART  = 4'd2,
        REGION_SPI   = 4'd3    // no hardware behind it
    } region_e;

    // clint register offsets
    localparam logic [7:0] CLINT_MSIP        = 8'h00;
    localparam logic [7:0] CLINT_MTIMECMP_LO = 8'h08;
    localparam logic [7:0] CLINT_MTIMECMP_HI = 8'h0C;
    localparam logic [7:0] CLINT_MTIME_LO    = 8'h10;
    localparam logic [7:0] CLINT_MTIME_HI    = 8'h14;

    // uart register offsets
    localparam logic [7:0] UART_TXDATA = 8'h00;
    localparam logic [7:0] UART_STATUS = 8'h04;   // bit0 busy, bit1 done
    localparam logic [7:0] UART_DIV    = 8'h08;

    // one strobe per data phase, already qualified by region
    typedef struct packed {
        logic        wr;
        logic        rd;
        logic [7:0]  offset;
        logic [31:0] wdata;
    } periph_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        stall;   // txdata write while a frame runs
    } uart_rsp_t;

    typedef struct packed {
        logic timer;
        logic software;
        logic uart;
    } irq_t;

endpackage

`default_nettype wire

/* rtl/ahb_pkg.sv */
`default_nettype none

package ahb_pkg;

    // htrans encodings
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_BUSY   = 2'b01;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    // ahb-lite has only okay and error
    localparam logic HRESP_OKAY  = 1'b0;
    localparam logic HRESP_ERROR = 1'b1;

    // master to slave
    typedef struct packed {
        logic        hsel;
        logic [31:0] haddr;
        logic [1:0]  htrans;
        logic        hwrite;
        logic [2:0]  hsize;    // word only
        logic [31:0] hwdata;   // data phase
    } ahb_req_t;

    // slave to master
    typedef struct packed {
        logic [31:0] hrdata;
        logic        hready;
        logic        hresp;
    } ahb_rsp_t;

endpackage

`default_nettype wire
